/* files.f */
hw/lsu_pkg.sv
hw/sbus_pkg.sv
hw/lsu.sv
hw/sbus_sram.sv
hw/lsu_top.sv
sim/lsu_checker.sv
sim/tb_lsu.sv

/* hw/lsu.sv */
`timescale 1ns/10ps

module lsu (
    input  logic                             clk,
    input  logic                             rst,
    input  lsu_pkg::lsu_req_t                req,
    output logic [lsu_pkg::DATA_WIDTH-1:0]   wreg,
    output logic                             rvalid,
    output logic                             wcomplete,
    output logic                             access_start,
    output sbus_pkg::sbus_wr_req_t           wr_req,
    input  sbus_pkg::sbus_wr_rsp_t           wr_rsp,
    output sbus_pkg::sbus_rd_req_t           rd_req,
    input  sbus_pkg::sbus_rd_rsp_t           rd_rsp
);

    logic                                wen_act;
    logic                                ren_act;
    logic                                wen_q;
    logic                                ren_q;
    logic                                wen_pos;
    logic                                ren_pos;
    logic [lsu_pkg::ADDR_WIDTH-1:0]      waddr;
    logic [lsu_pkg::ADDR_WIDTH-1:0]      raddr;
    logic [1:0]                          woff;
    logic [1:0]                          roff;
    logic [4:0]                          wshift;
    logic [lsu_pkg::DATA_WIDTH-1:0]      wdata_lane;
    logic [sbus_pkg::BUS_MASK_W-1:0]     wmask;
    logic [sbus_pkg::BUS_MASK_W-1:0]     rmask;
    logic [lsu_pkg::DATA_WIDTH-1:0]      rdata;
    logic [7:0]                          rbyte;
    logic [15:0]                         rhalf;

    // ------------------------------------------------------------------
    // enable edge detection
    // ------------------------------------------------------------------
    assign wen_act = req.valid & req.wen;
    assign ren_act = req.valid & req.ren;

    always_ff @(posedge clk) begin
        if (rst) begin
            wen_q <= 1'b0;
            ren_q <= 1'b0;
        end else begin
            wen_q <= wen_act;
            ren_q <= ren_act;
        end
    end

    // only the first cycle of a held enable starts an access
    assign wen_pos      = wen_act & ~wen_q;
    assign ren_pos      = ren_act & ~ren_q;
    assign access_start = wen_pos | ren_pos;

    assign waddr = wen_act ? req.addr : '0;
    assign raddr = ren_act ? req.addr : '0;
    assign woff  = waddr[1:0];
    assign roff  = raddr[1:0];

    // ------------------------------------------------------------------
    // store lane alignment
    // ------------------------------------------------------------------
    assign wshift = {woff, 3'b000};

    always_comb begin
        wmask      = '0;
        wdata_lane = '0;
        case (req.op)
            lsu_pkg::op_sb: begin
                wmask      = 4'b0001 << woff;
                wdata_lane = req.wdata << wshift;
            end
            lsu_pkg::op_sh: begin
                // odd offset leaves the mask empty
                if (!woff[0]) begin
                    wmask      = 4'b0011 << woff;
                    wdata_lane = req.wdata << wshift;
                end
            end
            lsu_pkg::op_sw: begin
                if (woff == 2'b00) begin
                    wmask      = 4'b1111;
                    wdata_lane = req.wdata;
                end
            end
            default: begin
                wmask      = '0;
                wdata_lane = '0;
            end
        endcase
    end

    // ------------------------------------------------------------------
    // load byte select and extension
    // ------------------------------------------------------------------
    assign rdata = rd_rsp.data;

    always_comb begin
        case (req.op)
            lsu_pkg::op_lw:                 rmask = 4'b1111;
            lsu_pkg::op_lh, lsu_pkg::op_lhu: rmask = roff[0] ? 4'b0000 : 4'b0011 << roff;
            lsu_pkg::op_lb, lsu_pkg::op_lbu: rmask = 4'b0001 << roff;
            default:                        rmask = '0;
        endcase
    end

    always_comb begin
        rbyte = '0;
        for (int i = 0; i < sbus_pkg::BUS_MASK_W; i++) begin
            if (rmask[i]) begin
                rbyte = rbyte | rdata[8*i +: 8];
            end
        end
    end

    assign rhalf = (rmask[1:0] == 2'b11) ? rdata[15:0]  :
                   (rmask[3:2] == 2'b11) ? rdata[31:16] : 16'h0000;

    always_comb begin
        case (req.op)
            lsu_pkg::op_lb:  wreg = {{(lsu_pkg::DATA_WIDTH-8){rbyte[7]}}, rbyte};
            lsu_pkg::op_lbu: wreg = {{(lsu_pkg::DATA_WIDTH-8){1'b0}}, rbyte};
            lsu_pkg::op_lh:  wreg = {{(lsu_pkg::DATA_WIDTH-16){rhalf[15]}}, rhalf};
            lsu_pkg::op_lhu: wreg = {{(lsu_pkg::DATA_WIDTH-16){1'b0}}, rhalf};
            lsu_pkg::op_lw:  wreg = rdata;
            default:         wreg = '0;
        endcase
    end

    // ------------------------------------------------------------------
    // bus side
    // ------------------------------------------------------------------
    always_comb begin
        wr_req.req  = wen_pos;
        wr_req.addr = waddr;
        wr_req.data = wdata_lane;
        wr_req.mask = wmask;
        rd_req.req  = ren_pos;
        rd_req.addr = raddr;
    end

    assign wcomplete = wr_rsp.complete;
    assign rvalid    = rd_rsp.complete;

    a_single_req: assert property (@(posedge clk) disable iff (rst)
        !(wr_req.req && rd_req.req))
        else $error("read and write request in the same cycle");

    // the memory answers every access after its fixed latency
    a_complete_latency: assert property (@(posedge clk) disable iff (rst)
        access_start |-> ##(sbus_pkg::MEM_LATENCY) (rvalid || wcomplete))
        else $error("access did not complete after the bus latency");

endmodule

/* hw/lsu_pkg.sv */
package lsu_pkg;

    localparam int DATA_WIDTH = 32;
    localparam int ADDR_WIDTH = 32;

    // ------------------------------------------------------------------
    // memory opcodes from the execute stage
    // ------------------------------------------------------------------
    typedef enum logic [3:0] {
        op_none = 4'd0,
        op_lb   = 4'd1,
        op_lh   = 4'd2,
        op_lw   = 4'd3,
        op_lbu  = 4'd4,
        op_lhu  = 4'd5,
        op_sb   = 4'd6,
        op_sh   = 4'd7,
        op_sw   = 4'd8
    } mem_op_e;

    // one access held steady until its complete pulse
    typedef struct packed {
        logic                  valid;
        logic                  ren;
        logic                  wen;
        mem_op_e               op;
        logic [ADDR_WIDTH-1:0] addr;
        logic [DATA_WIDTH-1:0] wdata;
    } lsu_req_t;

endpackage

/* hw/lsu_top.sv */
`timescale 1ns/10ps

module lsu_top (
    input  logic                           clk,
    input  logic                           rst,
    input  lsu_pkg::lsu_req_t              req,
    output logic [lsu_pkg::DATA_WIDTH-1:0] wreg,
    output logic                           rvalid,
    output logic                           wcomplete,
    output logic                           access_start
);

    sbus_pkg::sbus_wr_req_t wr_req;
    sbus_pkg::sbus_wr_rsp_t wr_rsp;
    sbus_pkg::sbus_rd_req_t rd_req;
    sbus_pkg::sbus_rd_rsp_t rd_rsp;

    lsu u_lsu (
        .clk          (clk),
        .rst          (rst),
        .req          (req),
        .wreg         (wreg),
        .rvalid       (rvalid),
        .wcomplete    (wcomplete),
        .access_start (access_start),
        .wr_req       (wr_req),
        .wr_rsp       (wr_rsp),
        .rd_req       (rd_req),
        .rd_rsp       (rd_rsp)
    );

    sbus_sram u_sram (
        .clk    (clk),
        .rst    (rst),
        .wr_req (wr_req),
        .wr_rsp (wr_rsp),
        .rd_req (rd_req),
        .rd_rsp (rd_rsp)
    );

endmodule

/* hw/sbus_pkg.sv */
package sbus_pkg;

    localparam int BUS_ADDR_W  = 32;
    localparam int BUS_DATA_W  = 32;
    localparam int BUS_MASK_W  = BUS_DATA_W / 8;

    localparam int MEM_WORDS   = 256;
    localparam int MEM_IDX_W   = $clog2(MEM_WORDS);
    localparam int MEM_LATENCY = 2;
    localparam int LAT_CNT_W   = $clog2(MEM_LATENCY + 1);

    localparam logic [1:0] RESP_OKAY = 2'b00;

    typedef logic [LAT_CNT_W-1:0] lat_cnt_t;

    // ------------------------------------------------------------------
    // simple bus channels
    // ------------------------------------------------------------------
    typedef struct packed {
        logic                  req;
        logic [BUS_ADDR_W-1:0] addr;
        logic [BUS_DATA_W-1:0] data;
        logic [BUS_MASK_W-1:0] mask;
    } sbus_wr_req_t;

    typedef struct packed {
        logic                  req;
        logic [BUS_ADDR_W-1:0] addr;
    } sbus_rd_req_t;

    typedef struct packed {
        logic [1:0] resp;
        logic       complete;
    } sbus_wr_rsp_t;

    typedef struct packed {
        logic [BUS_DATA_W-1:0] data;
        logic [1:0]            resp;
        logic                  complete;
    } sbus_rd_rsp_t;

endpackage

/* hw/sbus_sram.sv */
`timescale 1ns/10ps

module sbus_sram (
    input  logic                    clk,
    input  logic                    rst,
    input  sbus_pkg::sbus_wr_req_t  wr_req,
    output sbus_pkg::sbus_wr_rsp_t  wr_rsp,
    input  sbus_pkg::sbus_rd_req_t  rd_req,
    output sbus_pkg::sbus_rd_rsp_t  rd_rsp
);

    logic [sbus_pkg::BUS_DATA_W-1:0] mem [sbus_pkg::MEM_WORDS];
    logic [sbus_pkg::MEM_IDX_W-1:0]  widx;
    logic [sbus_pkg::MEM_IDX_W-1:0]  ridx;
    logic [sbus_pkg::BUS_DATA_W-1:0] rdata_q;
    sbus_pkg::lat_cnt_t              cnt;
    logic                            pend_rd;
    logic                            done;

    // word index without the byte offset bits
    assign widx = wr_req.addr[sbus_pkg::MEM_IDX_W+1:2];
    assign ridx = rd_req.addr[sbus_pkg::MEM_IDX_W+1:2];

    // ------------------------------------------------------------------
    // storage
    // ------------------------------------------------------------------
    initial begin
        for (int i = 0; i < sbus_pkg::MEM_WORDS; i++) begin
            mem[i] = '0;
        end
    end

    // masked bytes land on the request edge
    always @(posedge clk) begin
        if (wr_req.req) begin
            for (int b = 0; b < sbus_pkg::BUS_MASK_W; b++) begin
                if (wr_req.mask[b]) begin
                    mem[widx][8*b +: 8] <= wr_req.data[8*b +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_req.req) begin
            rdata_q <= mem[ridx];
        end
    end

    // ------------------------------------------------------------------
    // latency counter
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            cnt     <= '0;
            pend_rd <= 1'b0;
        end else if (wr_req.req || rd_req.req) begin
            cnt     <= sbus_pkg::lat_cnt_t'(sbus_pkg::MEM_LATENCY);
            pend_rd <= rd_req.req;
        end else if (cnt != '0) begin
            cnt <= cnt - 1'b1;
        end
    end

    // the last count puts complete MEM_LATENCY cycles after the request
    assign done = (cnt == sbus_pkg::lat_cnt_t'(1));

    always_comb begin
        wr_rsp.resp     = sbus_pkg::RESP_OKAY;
        wr_rsp.complete = done & ~pend_rd;
        rd_rsp.data     = rdata_q;
        rd_rsp.resp     = sbus_pkg::RESP_OKAY;
        rd_rsp.complete = done & pend_rd;
    end

    a_no_req_busy: assert property (@(posedge clk) disable iff (rst)
        (wr_req.req || rd_req.req) |-> (cnt == '0))
        else $error("bus request while the memory is busy");

endmodule

/* run.sh */
#!/bin/sh
# build and run the LSU testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_lsu \
    -Mdir obj_dir -f files.f > build.log 2>&1 &&
./obj_dir/Vtb_lsu > sim.log 2>&1 ||
{ tail -n 20 build.log; echo "Test FAILED" >> sim.log; }
cat sim.log
grep -q "Test FAILED" sim.log && exit 1 || exit 0

/* sim/lsu_checker.sv */
`timescale 1ns/10ps

module lsu_checker (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           access_start,
    input  logic                           rvalid,
    input  logic                           wcomplete,
    input  logic [lsu_pkg::DATA_WIDTH-1:0] wreg,
    input  int                             test_num,
    input  logic [127:0]                   test_name,
    input  lsu_pkg::mem_op_e               test_op,
    input  logic [lsu_pkg::DATA_WIDTH-1:0] test_exp,
    input  logic                           all_done,
    output int                             pass_cnt,
    output int                             fail_cnt,
    output int                             err_cnt
);

    // clock cycles from enable edge to complete pulse
    localparam int EXP_LATENCY = 2;

    int   cyc;
    int   start_cyc;
    int   last_test;
    int   lat;
    logic pending;
    logic is_ld;

    assign is_ld = test_op inside {lsu_pkg::op_lb, lsu_pkg::op_lh, lsu_pkg::op_lw,
                                   lsu_pkg::op_lbu, lsu_pkg::op_lhu};

    // ------------------------------------------------------------------
    // access tracking on the rising clock edge
    // ------------------------------------------------------------------
    always @(posedge clk) begin
        if (rst) begin
            cyc       = 0;
            start_cyc = 0;
            last_test = -1;
            pending   = 1'b0;
            pass_cnt  = 0;
            fail_cnt  = 0;
            err_cnt   = 0;
        end else begin
            cyc = cyc + 1;
            if (access_start) begin
                if (test_num == last_test || pending) begin
                    $display("%0s started a second request before the enable dropped",
                             test_name);
                    err_cnt++;
                end
                pending   = 1'b1;
                start_cyc = cyc;
                last_test = test_num;
            end
            if (rvalid || wcomplete) begin
                lat = cyc - start_cyc;
                if (!pending) begin
                    $display("complete pulse with no access open during %0s", test_name);
                    err_cnt++;
                end else if (lat != EXP_LATENCY) begin
                    $display("FAIL %0s completed %0d cycles after its request, not %0d",
                             test_name, lat, EXP_LATENCY);
                    fail_cnt++;
                end else if (is_ld != rvalid || (rvalid && wcomplete)) begin
                    $display("FAIL %0s got the wrong kind of complete pulse", test_name);
                    fail_cnt++;
                end else if (is_ld && wreg !== test_exp) begin
                    $display("ERR %0s expected %08h actual %08h", test_name, test_exp, wreg);
                    fail_cnt++;
                end else begin
                    $display("PASS %0s", test_name);
                    pass_cnt++;
                end
                pending = 1'b0;
            end else if (pending && cyc - start_cyc > EXP_LATENCY) begin
                $display("%0s never received a complete pulse", test_name);
                err_cnt++;
                pending = 1'b0;
            end
        end
    end

    always @(posedge all_done) begin
        $display("results: %0d passed, %0d failed, %0d other errors",
                 pass_cnt, fail_cnt, err_cnt);
    end

endmodule

/* sim/lsu_tests.txt */
# columns: name opcode address store_data expected_load (all hex)
# expected_load is ignored for stores
rst_zero     lw   00000040 00000000 00000000
sw_word      sw   00000100 deadbeef 00000000
lw_word      lw   00000100 00000000 deadbeef
sb_lane0     sb   00000104 00000081 00000000
sb_lane1     sb   00000105 0000007f 00000000
sb_lane2     sb   00000106 aaaa55c3 00000000
sb_lane3     sb   00000107 00000024 00000000
lbu_lane0    lbu  00000104 00000000 00000081
lb_lane0     lb   00000104 00000000 ffffff81
lbu_lane1    lbu  00000105 00000000 0000007f
lb_lane1     lb   00000105 00000000 0000007f
lbu_lane2    lbu  00000106 00000000 000000c3
lb_lane2     lb   00000106 00000000 ffffffc3
lbu_lane3    lbu  00000107 00000000 00000024
lb_lane3     lb   00000107 00000000 00000024
lw_bytes     lw   00000104 00000000 24c37f81
sh_lo        sh   00000108 ffff8001 00000000
sh_hi        sh   0000010a 00005aa5 00000000
lh_lo        lh   00000108 00000000 ffff8001
lhu_lo       lhu  00000108 00000000 00008001
lh_hi        lh   0000010a 00000000 00005aa5
lw_halves    lw   00000108 00000000 5aa58001
sw_base      sw   0000010c 11223344 00000000
sh_odd       sh   0000010d 0000ffff 00000000
sw_mis       sw   0000010e cafef00d 00000000
lw_unchanged lw   0000010c 00000000 11223344
lh_off3      lh   0000010f 00000000 00000000
lw_low_bits  lw   0000010f 00000000 11223344

/* sim/tb_lsu.sv */
`timescale 1ns/10ps

module tb_lsu;

    localparam int MAX_TESTS = 64;

    logic                           clk;
    logic                           rst;
    lsu_pkg::lsu_req_t              req;
    logic [lsu_pkg::DATA_WIDTH-1:0] wreg;
    logic                           rvalid;
    logic                           wcomplete;
    logic                           access_start;
    logic                           all_done;
    int                             test_num;
    logic [127:0]                   test_name;
    lsu_pkg::mem_op_e               test_op;
    logic [31:0]                    test_exp;
    int                             pass_cnt;
    int                             fail_cnt;
    int                             err_cnt;
    int                             n_tests;
    int                             cyc_limit;
    int                             cyc_cnt = 0;
    logic                           load_ok;

    // one test table entry per data line
    logic [127:0]      t_name  [MAX_TESTS];
    lsu_pkg::mem_op_e  t_op    [MAX_TESTS];
    logic [31:0]       t_addr  [MAX_TESTS];
    logic [31:0]       t_wdata [MAX_TESTS];
    logic [31:0]       t_exp   [MAX_TESTS];

    lsu_top u_lsu_top (.*);

    lsu_checker u_checker (.*);

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    always @(posedge clk) begin
        cyc_cnt <= cyc_cnt + 1;
        if (cyc_limit > 0 && cyc_cnt >= cyc_limit) begin
            $display("timeout after %0d cycles, an access never completed", cyc_cnt);
            $display("Test FAILED");
            $finish;
        end
    end

    function automatic lsu_pkg::mem_op_e op_from_name(input logic [63:0] nm);
        case (nm)
            "lb":    return lsu_pkg::op_lb;
            "lh":    return lsu_pkg::op_lh;
            "lw":    return lsu_pkg::op_lw;
            "lbu":   return lsu_pkg::op_lbu;
            "lhu":   return lsu_pkg::op_lhu;
            "sb":    return lsu_pkg::op_sb;
            "sh":    return lsu_pkg::op_sh;
            "sw":    return lsu_pkg::op_sw;
            default: return lsu_pkg::op_none;
        endcase
    endfunction

    // ------------------------------------------------------------------
    // test file reader
    // ------------------------------------------------------------------
    // lines led by a lone # are comments
    task automatic read_tests();
        int           fd;
        int           code;
        logic [127:0] tok;
        logic [63:0]  op_name;
        logic [959:0] rest;
        n_tests = 0;
        load_ok = 1'b1;
        fd = $fopen("sim/lsu_tests.txt", "r");
        if (fd == 0) begin
            $display("cannot open the test file sim/lsu_tests.txt");
            load_ok = 1'b0;
        end else begin
            while (!$feof(fd) && load_ok) begin
                code = $fscanf(fd, "%s", tok);
                if (code == 1 && tok[7:0] == "#" && tok[127:8] == '0) begin
                    code = $fgets(rest, fd);
                end else if (code == 1) begin
                    code = $fscanf(fd, "%s %h %h %h", op_name, t_addr[n_tests],
                                   t_wdata[n_tests], t_exp[n_tests]);
                    t_name[n_tests] = tok;
                    t_op[n_tests]   = op_from_name(op_name);
                    if (code != 4 || t_op[n_tests] == lsu_pkg::op_none
                            || n_tests == MAX_TESTS - 1) begin
                        $display("malformed test line starting with %0s", tok);
                        load_ok = 1'b0;
                    end
                    n_tests++;
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic run_test(input int idx);
        int gap;
        gap       = $urandom_range(3, 0);
        test_num  = idx;
        test_name = t_name[idx];
        test_op   = t_op[idx];
        test_exp  = t_exp[idx];
        req.valid = 1'b1;
        req.op    = t_op[idx];
        req.addr  = t_addr[idx];
        req.wdata = t_wdata[idx];
        req.ren   = t_op[idx] inside {lsu_pkg::op_lb, lsu_pkg::op_lh, lsu_pkg::op_lw,
                                      lsu_pkg::op_lbu, lsu_pkg::op_lhu};
        req.wen   = ~req.ren;
        do begin
            @(posedge clk);
        end while (!(rvalid || wcomplete));
        // odd tests keep the enable high one cycle past complete
        repeat (idx % 2) @(posedge clk);
        #10;
        req.valid = 1'b0;
        req.ren   = 1'b0;
        req.wen   = 1'b0;
        @(posedge clk);
        repeat (gap) @(posedge clk);
        #10;
    endtask

    initial begin
        void'($urandom(32'h0ea9_2697));
        rst       = 1'b1;
        req       = '0;
        all_done  = 1'b0;
        test_num  = -1;
        test_name = '0;
        test_op   = lsu_pkg::op_none;
        test_exp  = '0;
        cyc_limit = 0;
        read_tests();
        cyc_limit = n_tests * 8 + 40;
        repeat (10) @(posedge clk);
        #10;
        rst = 1'b0;
        @(posedge clk);
        #10;
        if (load_ok) begin
            for (int i = 0; i < n_tests; i++) begin
                run_test(i);
            end
        end
        all_done = 1'b1;
        #1;
        if (!load_ok || n_tests == 0 || fail_cnt != 0 || err_cnt != 0
                || pass_cnt != n_tests) begin
            $display("Test FAILED");
        end else begin
            $display("Test OK");
        end
        $finish;
    end

endmodule
